/* design/soc_bus_pkg.sv */
// ----------------------------------------------------------
// AHB-lite and APB bus definitions for the APB subsystem
// Word transfers only, no HSIZE, HBURST or HPROT support
// Peripherals decode fixed 64 KB windows on the upper bits
// ----------------------------------------------------------
package soc_bus_pkg;

  typedef logic [31:0] addr_t;     // Byte address
  typedef logic [31:0] data_t;     // Bus data word

  // AHB transfer type
  typedef logic [1:0] htrans_t;
  localparam htrans_t HTRANS_IDLE   = 2'b00;
  localparam htrans_t HTRANS_NONSEQ = 2'b10;

  // AHB slave response
  typedef logic [1:0] hresp_t;
  localparam hresp_t HRESP_OKAY  = 2'b00;
  localparam hresp_t HRESP_ERROR = 2'b01;

  // ----------------------------------------------------------
  // Address map
  // ----------------------------------------------------------
  localparam int    WINDOW_BITS = 16;              // Offset bits inside a window
  localparam addr_t GPIO_BASE   = 32'h0082_0000;   // GPIO slot
  localparam addr_t IRQC_BASE   = 32'h0086_0000;   // Interrupt controller slot

  // Bridge sequencer
  typedef enum logic [2:0] {
    IDLE,     // Ready for a new address
    SETUP,    // APB setup, write data captured
    ACCESS,   // APB access, read data captured
    ERR1,     // First error cycle, HREADY low
    ERR2      // Second error cycle, HREADY high
  } bridge_state_t;

endpackage

/* design/periph_regs_pkg.sv */
// ----------------------------------------------------------
// Register map of the GPIO and interrupt controller
// Offsets are word aligned, decoded on PADDR[7:0] only
// ----------------------------------------------------------
package periph_regs_pkg;

  typedef logic [7:0] reg_off_t;

  // GPIO
  localparam reg_off_t GPIO_OUT_OFF   = 8'h00;  // Pin output value
  localparam reg_off_t GPIO_OE_OFF    = 8'h04;  // Output enable, 1 drives
  localparam reg_off_t GPIO_IN_OFF    = 8'h08;  // Synchronized pins, RO
  localparam reg_off_t GPIO_IEN_OFF   = 8'h0C;  // Rising edge irq enable
  localparam reg_off_t GPIO_ISTAT_OFF = 8'h10;  // Edge status, W1C

  // Interrupt controller
  localparam reg_off_t IRQ_RAW_OFF  = 8'h00;    // Raw sources, RO
  localparam reg_off_t IRQ_MASK_OFF = 8'h04;    // Enable per source
  localparam reg_off_t IRQ_HIB_OFF  = 8'h08;    // Bit 0 is hibernate

  // Interrupt sources
  localparam int EXT_IRQS     = 4;
  localparam int NUM_IRQS     = EXT_IRQS + 1;
  localparam int IRQ_SRC_GPIO = 0;               // External line k at k+1

  typedef logic [NUM_IRQS-1:0] irq_vec_t;

endpackage

/* design/apb_if.sv */
// ----------------------------------------------------------
// APB bundle between bridge and one peripheral
// No PREADY or PSLVERR, slaves have zero wait states
// ----------------------------------------------------------
`timescale 1ns/1ps

interface apb_if;
  import soc_bus_pkg::*;

  addr_t paddr;
  logic  psel;
  logic  penable;
  logic  pwrite;
  data_t pwdata;
  data_t prdata;

  modport master (output paddr, psel, penable, pwrite, pwdata,
                  input  prdata);

  modport slave  (input  paddr, psel, penable, pwrite, pwdata,
                  output prdata);

endinterface

/* design/ahb_apb_bridge.sv */
// ----------------------------------------------------------
// AHB-lite slave to APB bridge, one transfer in flight
// Mapped access takes 3 data phase cycles, miss takes 2
// HWDATA sampled in the cycle after the address phase
// Only NONSEQ starts a transfer, SEQ and BUSY are ignored
// ----------------------------------------------------------
`timescale 1ns/1ps

module ahb_apb_bridge (
  input  logic                 i_hclk,
  input  logic                 i_rst_n,
  input  logic                 i_hsel,
  input  logic                 i_hready_in,
  input  logic                 i_hwrite,
  input  soc_bus_pkg::addr_t   i_haddr,
  input  soc_bus_pkg::htrans_t i_htrans,
  input  soc_bus_pkg::data_t   i_hwdata,
  output soc_bus_pkg::data_t   o_hrdata,
  output logic                 o_hready,
  output soc_bus_pkg::hresp_t  o_hresp,
  apb_if.master                m_gpio,
  apb_if.master                m_irqc
);
  import soc_bus_pkg::*;

  bridge_state_t state_q, state_d;
  addr_t         addr_q;                 // Captured address phase
  data_t         wdata_q;                // Write data held for ACCESS
  logic          write_q;
  logic          sel_gpio_q, sel_irqc_q; // One-hot slave select, 0/0 on miss
  logic          hit_gpio, hit_irqc;
  logic          accept;
  logic          apb_phase;

  // Window decode on the upper address bits
  assign hit_gpio = (i_haddr[31:WINDOW_BITS] == GPIO_BASE[31:WINDOW_BITS]);
  assign hit_irqc = (i_haddr[31:WINDOW_BITS] == IRQC_BASE[31:WINDOW_BITS]);

  assign accept = i_hsel && i_hready_in && o_hready && (i_htrans == HTRANS_NONSEQ);

  // ----------------------------------------------------------
  // Sequencer
  // ----------------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE, ERR2: begin          // Both cycles have HREADY high
        if (accept) begin
          state_d = (hit_gpio || hit_irqc) ? SETUP : ERR1;
        end else begin
          state_d = IDLE;
        end
      end
      SETUP:   state_d = ACCESS;
      ACCESS:  state_d = IDLE;   // Read data is in o_hrdata now
      ERR1:    state_d = ERR2;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge i_hclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_q    <= IDLE;
      write_q    <= 1'b0;
      sel_gpio_q <= 1'b0;
      sel_irqc_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        write_q    <= i_hwrite;
        sel_gpio_q <= hit_gpio;
        sel_irqc_q <= hit_irqc;
      end
    end
  end

  // Address, write and read data paths
  always_ff @(posedge i_hclk) begin
    if (accept) begin
      addr_q <= i_haddr;
    end
    if (state_q == SETUP) begin
      wdata_q <= i_hwdata;       // Data phase of the AHB write
    end
    if (state_q == ACCESS && !write_q) begin
      o_hrdata <= sel_gpio_q ? m_gpio.prdata : m_irqc.prdata;
    end
  end

  // ----------------------------------------------------------
  // APB drive, shared bus with per-slave PSEL
  // ----------------------------------------------------------
  assign apb_phase = (state_q == SETUP) || (state_q == ACCESS);

  assign m_gpio.paddr   = addr_q;
  assign m_gpio.pwrite  = write_q;
  assign m_gpio.pwdata  = (state_q == SETUP) ? i_hwdata : wdata_q;
  assign m_gpio.psel    = apb_phase && sel_gpio_q;
  assign m_gpio.penable = (state_q == ACCESS);

  assign m_irqc.paddr   = addr_q;
  assign m_irqc.pwrite  = write_q;
  assign m_irqc.pwdata  = (state_q == SETUP) ? i_hwdata : wdata_q;
  assign m_irqc.psel    = apb_phase && sel_irqc_q;
  assign m_irqc.penable = (state_q == ACCESS);

  // AHB response
  assign o_hready = (state_q == IDLE) || (state_q == ERR2);
  assign o_hresp  = (state_q == ERR1 || state_q == ERR2) ? HRESP_ERROR : HRESP_OKAY;

endmodule

/* design/gpio_apb.sv */
// ----------------------------------------------------------
// GPIO with output enable and rising edge interrupts
// GPIO_WIDTH from 1 to 32, upper data bits read as zero
// Inputs go through a two-flop synchronizer, no debounce
// ----------------------------------------------------------
`timescale 1ns/1ps

module gpio_apb #(
  parameter int GPIO_WIDTH = 16
) (
  input  logic                  i_hclk,
  input  logic                  i_rst_n,
  apb_if.slave                  s_apb,
  input  logic [GPIO_WIDTH-1:0] i_gpio_in,
  output logic [GPIO_WIDTH-1:0] o_gpio_out,
  output logic [GPIO_WIDTH-1:0] o_gpio_oe_n,
  output logic                  o_gpio_irq
);
  import soc_bus_pkg::*;
  import periph_regs_pkg::*;

  logic [GPIO_WIDTH-1:0] out_q, oe_q, ien_q, stat_q;
  logic [GPIO_WIDTH-1:0] sync1_q, sync2_q;  // Pin synchronizer
  logic [GPIO_WIDTH-1:0] prev_q;            // Last synchronized value
  logic [GPIO_WIDTH-1:0] rise, stat_clr;
  logic [GPIO_WIDTH-1:0] wdata;
  reg_off_t              off;
  logic                  wr_en;
  data_t                 rdata;

  assign off   = s_apb.paddr[7:0];
  assign wdata = s_apb.pwdata[GPIO_WIDTH-1:0];
  assign wr_en = s_apb.psel && s_apb.penable && s_apb.pwrite;  // ACCESS only

  assign rise     = sync2_q & ~prev_q & ien_q;
  assign stat_clr = (wr_en && off == GPIO_ISTAT_OFF) ? wdata : '0;  // W1C

  always_ff @(posedge i_hclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      out_q   <= '0;
      oe_q    <= '0;          // All pins tristate
      ien_q   <= '0;
      stat_q  <= '0;
      sync1_q <= '0;
      sync2_q <= '0;
      prev_q  <= '0;
    end else begin
      sync1_q <= i_gpio_in;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
      stat_q  <= (stat_q & ~stat_clr) | rise;   // New edge wins over clear
      if (wr_en) begin
        case (off)
          GPIO_OUT_OFF: out_q <= wdata;
          GPIO_OE_OFF:  oe_q  <= wdata;
          GPIO_IEN_OFF: ien_q <= wdata;
          default: ;                // IN and ISTAT handled above
        endcase
      end
    end
  end

  // Read mux
  always_comb begin
    rdata = '0;
    case (off)
      GPIO_OUT_OFF:   rdata[GPIO_WIDTH-1:0] = out_q;
      GPIO_OE_OFF:    rdata[GPIO_WIDTH-1:0] = oe_q;
      GPIO_IN_OFF:    rdata[GPIO_WIDTH-1:0] = sync2_q;
      GPIO_IEN_OFF:   rdata[GPIO_WIDTH-1:0] = ien_q;
      GPIO_ISTAT_OFF: rdata[GPIO_WIDTH-1:0] = stat_q;
      default:        rdata = '0;
    endcase
  end

  assign s_apb.prdata = rdata;
  assign o_gpio_out   = out_q;
  assign o_gpio_oe_n  = ~oe_q;   // Pad enable is active low
  assign o_gpio_irq   = |stat_q;

endmodule

/* design/irq_ctrl.sv */
// ----------------------------------------------------------
// Interrupt gather, mask and wake source selection
// Sources are level sensitive, nothing is latched here
// Hibernate limits wake to the GPIO interrupt only
// ----------------------------------------------------------
`timescale 1ns/1ps

module irq_ctrl (
  input  logic                                i_hclk,
  input  logic                                i_rst_n,
  apb_if.slave                                s_apb,
  input  logic                                i_gpio_irq,
  input  logic [periph_regs_pkg::EXT_IRQS-1:0] i_ext_irq,
  output logic                                o_irq,
  output logic                                o_wake
);
  import soc_bus_pkg::*;
  import periph_regs_pkg::*;

  irq_vec_t raw;
  irq_vec_t mask_q;
  logic     hib_q;        // Set while the system hibernates
  reg_off_t off;
  logic     wr_en;
  data_t    rdata;

  // Raw vector, GPIO at the bottom
  always_comb begin
    raw                                = '0;
    raw[IRQ_SRC_GPIO]                  = i_gpio_irq;
    raw[IRQ_SRC_GPIO+1 +: EXT_IRQS]    = i_ext_irq;
  end

  assign off   = s_apb.paddr[7:0];
  assign wr_en = s_apb.psel && s_apb.penable && s_apb.pwrite;

  always_ff @(posedge i_hclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      mask_q <= '0;
      hib_q  <= 1'b0;
    end else if (wr_en) begin
      case (off)
        IRQ_MASK_OFF: mask_q <= s_apb.pwdata[NUM_IRQS-1:0];
        IRQ_HIB_OFF:  hib_q  <= s_apb.pwdata[0];
        default: ;      // RAW is read only
      endcase
    end
  end

  always_comb begin
    rdata = '0;
    case (off)
      IRQ_RAW_OFF:  rdata[NUM_IRQS-1:0] = raw;
      IRQ_MASK_OFF: rdata[NUM_IRQS-1:0] = mask_q;
      IRQ_HIB_OFF:  rdata[0]            = hib_q;
      default:      rdata = '0;
    endcase
  end

  assign s_apb.prdata = rdata;
  assign o_irq  = |(raw & mask_q);                       // To the processor
  assign o_wake = hib_q ? raw[IRQ_SRC_GPIO] : (|raw);    // Unmasked on purpose

endmodule

/* design/apb_subsystem.sv */
// ----------------------------------------------------------
// APB subsystem top, AHB-lite slave with GPIO and IRQ ctrl
// Single clock, APB runs on hclk
// GPIO at 0x0082_0000, IRQ controller at 0x0086_0000
// ----------------------------------------------------------
`timescale 1ns/1ps

module apb_subsystem #(
  parameter int GPIO_WIDTH = 16
) (
  input  logic                                 i_hclk,
  input  logic                                 i_rst_n,
  // AHB-lite slave
  input  logic                                 i_hsel,
  input  logic                                 i_hready_in,
  input  logic                                 i_hwrite,
  input  soc_bus_pkg::addr_t                   i_haddr,
  input  soc_bus_pkg::htrans_t                 i_htrans,
  input  soc_bus_pkg::data_t                   i_hwdata,
  output soc_bus_pkg::data_t                   o_hrdata,
  output logic                                 o_hready,
  output soc_bus_pkg::hresp_t                  o_hresp,
  // Pins
  input  logic [GPIO_WIDTH-1:0]                i_gpio_in,
  output logic [GPIO_WIDTH-1:0]                o_gpio_out,
  output logic [GPIO_WIDTH-1:0]                o_gpio_oe_n,
  // Interrupts
  input  logic [periph_regs_pkg::EXT_IRQS-1:0] i_ext_irq,
  output logic                                 o_irq,
  output logic                                 o_wake
);

  apb_if apb_gpio ();
  apb_if apb_irqc ();

  logic gpio_irq;   // GPIO edge interrupt into the controller

  ahb_apb_bridge u_bridge (
    .i_hclk      (i_hclk),
    .i_rst_n     (i_rst_n),
    .i_hsel      (i_hsel),
    .i_hready_in (i_hready_in),
    .i_hwrite    (i_hwrite),
    .i_haddr     (i_haddr),
    .i_htrans    (i_htrans),
    .i_hwdata    (i_hwdata),
    .o_hrdata    (o_hrdata),
    .o_hready    (o_hready),
    .o_hresp     (o_hresp),
    .m_gpio      (apb_gpio.master),
    .m_irqc      (apb_irqc.master)
  );

  gpio_apb #(
    .GPIO_WIDTH (GPIO_WIDTH)
  ) u_gpio (
    .i_hclk      (i_hclk),
    .i_rst_n     (i_rst_n),
    .s_apb       (apb_gpio.slave),
    .i_gpio_in   (i_gpio_in),
    .o_gpio_out  (o_gpio_out),
    .o_gpio_oe_n (o_gpio_oe_n),
    .o_gpio_irq  (gpio_irq)
  );

  irq_ctrl u_irqc (
    .i_hclk     (i_hclk),
    .i_rst_n    (i_rst_n),
    .s_apb      (apb_irqc.slave),
    .i_gpio_irq (gpio_irq),
    .i_ext_irq  (i_ext_irq),
    .o_irq      (o_irq),
    .o_wake     (o_wake)
  );

endmodule

/* verification/apb_subsystem_checker.sv */
// ----------------------------------------------------------
// Result checker for the APB subsystem ports
// Transfers timed from acceptance to HREADY high
// Compares on the falling edge, where outputs have settled
// ----------------------------------------------------------
`timescale 1ns/1ps

module apb_subsystem_checker #(
  parameter int GPIO_WIDTH = 16
) (
  input logic                  i_hclk,
  input logic                  i_rst_n,
  input logic                  i_hsel,
  input logic                  i_hready_in,
  input soc_bus_pkg::htrans_t  i_htrans,
  input logic                  i_hready,
  input soc_bus_pkg::hresp_t   i_hresp,
  input soc_bus_pkg::data_t    i_hrdata,
  input logic [GPIO_WIDTH-1:0] i_gpio_out,
  input logic [GPIO_WIDTH-1:0] i_gpio_oe_n,
  input logic                  i_irq,
  input logic                  i_wake
);
  import soc_bus_pkg::*;

  int     pass_cnt  = 0;
  int     fail_cnt  = 0;
  int     xfer_seq  = 0;    // Bumped per expected transfer
  int     xfer_took = 0;
  int     port_seq  = 0;    // Bumped per port check
  int     port_took = 0;
  int     cycles    = 0;    // Data phase length so far
  logic   active    = 1'b0;
  string  xfer_name, port_name;
  logic   xfer_read;
  hresp_t exp_resp;
  data_t  exp_data, port_exp;
  addr_t  port_sel;

  task automatic expect_xfer(input string name, input logic rd,
                             input hresp_t resp, input data_t data);
    xfer_name = name;
    xfer_read = rd;
    exp_resp  = resp;
    exp_data  = data;
    xfer_seq++;
  endtask

  // Port select: 0 pin out, 1 pin oe_n, 2 irq, 3 wake
  task automatic expect_port(input string name, input addr_t sel, input data_t exp);
    port_name = name;
    port_sel  = sel;
    port_exp  = exp;
    port_seq++;
  endtask

  function automatic data_t port_value(input addr_t sel);
    data_t v;
    v = '0;
    case (sel)
      0:       v[GPIO_WIDTH-1:0] = i_gpio_out;
      1:       v[GPIO_WIDTH-1:0] = i_gpio_oe_n;
      2:       v[0] = i_irq;
      3:       v[0] = i_wake;
      default: v = 'x;
    endcase
    return v;
  endfunction

  task automatic log_result(input string name, input string what,
                            input data_t exp, input data_t act);
    if (exp === act) begin
      pass_cnt++;
      $display("PASS %s", name);
    end else begin
      fail_cnt++;
      $display("FAIL %s %s expected %h actual %h", name, what, exp, act);
    end
  endtask

  // OKAY takes 3 data phase cycles, ERROR takes 2
  task automatic finish_xfer();
    int exp_cycles;
    exp_cycles = (exp_resp == HRESP_ERROR) ? 2 : 3;
    if (i_hresp !== exp_resp)
      log_result(xfer_name, "hresp", data_t'(exp_resp), data_t'(i_hresp));
    else if (cycles != exp_cycles)
      log_result(xfer_name, "cycles", data_t'(exp_cycles), data_t'(cycles));
    else if (xfer_read && exp_resp == HRESP_OKAY)
      log_result(xfer_name, "hrdata", exp_data, i_hrdata);
    else
      log_result(xfer_name, "hresp", data_t'(exp_resp), data_t'(i_hresp));
  endtask

  always @(posedge i_hclk or negedge i_hclk) begin
    if (i_hclk) begin
      // AHB address phase taken on this edge
      if (i_rst_n && i_hsel && i_hready_in && i_hready && i_htrans == HTRANS_NONSEQ) begin
        if (xfer_seq != xfer_took) begin
          xfer_took = xfer_seq;
          active    = 1'b1;
          cycles    = 0;
        end else begin
          fail_cnt++;
          $display("a transfer was accepted with no expected result");
        end
      end
    end else begin
      if (active) begin
        cycles++;
        if (i_hready) begin   // Last data phase cycle
          active = 1'b0;
          finish_xfer();
        end
      end
      if (port_seq != port_took) begin
        port_took = port_seq;
        log_result(port_name, "port", port_exp, port_value(port_sel));
      end
    end
  end

endmodule

/* verification/tb_apb_subsystem.sv */
// ----------------------------------------------------------
// Testbench for the APB subsystem, driven from a vector file
// Run from the project root, reads verification/golden_vectors.txt
// One AHB transfer at a time, HTRANS IDLE between transfers
// ----------------------------------------------------------
`timescale 1ns/1ps

module tb_apb_subsystem;
  import soc_bus_pkg::*;
  import periph_regs_pkg::*;

  localparam int GPIO_WIDTH     = 16;
  localparam int CYCLES_PER_VEC = 8;
  localparam int CYCLE_MARGIN   = 50;   // Reset and drain
  localparam int PIN_SETTLE     = 4;    // Two sync flops plus edge detect

  logic                  hclk, rst_n, hsel, hready_in, hwrite;
  logic                  hready, irq, wake;
  addr_t                 haddr;
  htrans_t               htrans;
  data_t                 hwdata, hrdata;
  hresp_t                hresp;
  logic [GPIO_WIDTH-1:0] gpio_in, gpio_out, gpio_oe_n;
  logic [EXT_IRQS-1:0]   ext_irq;

  // Vector table, one entry per file line
  string op_q[$];
  addr_t addr_q[$];
  data_t data_q[$];
  data_t exp_q[$];
  string name_q[$];

  int cycle_cnt   = 0;
  int cycle_limit = CYCLE_MARGIN;   // Raised once the vectors are in
  int n_checks    = 0;
  int bad_lines   = 0;

  apb_subsystem #(.GPIO_WIDTH(GPIO_WIDTH)) dut (
    .i_hclk(hclk), .i_rst_n(rst_n), .i_hsel(hsel), .i_hready_in(hready_in),
    .i_hwrite(hwrite), .i_haddr(haddr), .i_htrans(htrans), .i_hwdata(hwdata),
    .o_hrdata(hrdata), .o_hready(hready), .o_hresp(hresp),
    .i_gpio_in(gpio_in), .o_gpio_out(gpio_out), .o_gpio_oe_n(gpio_oe_n),
    .i_ext_irq(ext_irq), .o_irq(irq), .o_wake(wake)
  );

  apb_subsystem_checker #(.GPIO_WIDTH(GPIO_WIDTH)) u_checker (
    .i_hclk(hclk), .i_rst_n(rst_n), .i_hsel(hsel), .i_hready_in(hready_in),
    .i_htrans(htrans), .i_hready(hready), .i_hresp(hresp), .i_hrdata(hrdata),
    .i_gpio_out(gpio_out), .i_gpio_oe_n(gpio_oe_n), .i_irq(irq), .i_wake(wake)
  );

  initial begin
    hclk = 1'b0;
    forever #50 hclk = ~hclk;   // 100 ns period
  end

  // ----------------------------------------------------------
  // Vector file reader, lines starting with # are skipped
  // ----------------------------------------------------------
  task automatic load_vectors();
    int    fd;
    int    n;
    string line, op, name;
    addr_t a;
    data_t d, e;
    fd = $fopen("verification/golden_vectors.txt", "r");
    if (fd == 0) begin
      $display("cannot open the vector file verification/golden_vectors.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (n > 0 && line.getc(0) != "#") begin
          n = $sscanf(line, "%s %h %h %h %s", op, a, d, e, name);
          if (n == 5) begin
            op_q.push_back(op);
            addr_q.push_back(a);
            data_q.push_back(d);
            exp_q.push_back(e);
            name_q.push_back(name);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // Single AHB transfer, W expects HRESP in the expect column, R in data
  task automatic ahb_transfer(input logic write, input int i);
    hresp_t resp;
    data_t  rdata;
    resp  = write ? exp_q[i][1:0] : data_q[i][1:0];
    rdata = write ? '0 : exp_q[i];
    @(posedge hclk);
    u_checker.expect_xfer(name_q[i], !write, resp, rdata);
    hsel   <= 1'b1;
    hwrite <= write;
    haddr  <= addr_q[i];
    htrans <= HTRANS_NONSEQ;
    @(posedge hclk);                  // Address phase accepted here
    hsel   <= 1'b0;
    htrans <= HTRANS_IDLE;
    hwdata <= write ? data_q[i] : '0; // Data phase
    do @(negedge hclk); while (hready !== 1'b1);
  endtask

  task automatic run_vector(input int i);
    if (op_q[i] == "W" || op_q[i] == "R") begin
      n_checks++;
      ahb_transfer(op_q[i] == "W", i);
    end else if (op_q[i] == "P" || op_q[i] == "E") begin
      @(posedge hclk);
      if (op_q[i] == "P") gpio_in <= data_q[i][GPIO_WIDTH-1:0];
      else ext_irq <= data_q[i][EXT_IRQS-1:0];
      repeat (PIN_SETTLE) @(posedge hclk);
    end else if (op_q[i] == "C") begin
      n_checks++;
      @(posedge hclk);
      u_checker.expect_port(name_q[i], addr_q[i], exp_q[i]);
      @(negedge hclk);                // Checker samples on this edge
    end else begin
      bad_lines++;
      $display("unknown operation %s on vector %s", op_q[i], name_q[i]);
    end
  endtask

  initial begin
    rst_n     <= 1'b0;
    hsel      <= 1'b0;
    hready_in <= 1'b1;   // Single slave, bus always ready
    hwrite    <= 1'b0;
    haddr     <= '0;
    htrans    <= HTRANS_IDLE;
    hwdata    <= '0;
    gpio_in   <= '0;
    ext_irq   <= '0;
    load_vectors();
    cycle_limit = CYCLES_PER_VEC * op_q.size() + CYCLE_MARGIN;
    repeat (3) @(posedge hclk);
    rst_n <= 1'b1;
    for (int i = 0; i < op_q.size(); i++) begin
      run_vector(i);
    end
    @(posedge hclk);
    $display("%0d tests passed, %0d failed", u_checker.pass_cnt, u_checker.fail_cnt);
    if (u_checker.fail_cnt == 0 && bad_lines == 0 && n_checks > 0 &&
        u_checker.pass_cnt == n_checks) begin
      $display("sim passed");
    end else begin
      if (u_checker.pass_cnt + u_checker.fail_cnt != n_checks)
        $display("expected %0d test results but some never reported", n_checks);
      $display("sim failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    while (cycle_cnt < cycle_limit) begin
      @(posedge hclk);
      cycle_cnt++;
    end
    $display("run timed out after %0d cycles", cycle_cnt);
    $display("sim failed");
    $finish;
  end

endmodule

/* verification/golden_vectors.txt */
# op addr data expect name. W: data written, expect is HRESP. R: data is HRESP, expect is read data
# P: data to pins. E: data to ext lines. C: addr picks 0 out, 1 oe_n, 2 irq, 3 wake
W 00820000 0000a5c3 00000000 wr_out
W 00820004 000000ff 00000000 wr_oe
C 00000000 00000000 0000a5c3 pin_out
C 00000001 00000000 0000ff00 pin_oe_n
R 00820000 00000000 0000a5c3 rd_out
R 00820004 00000000 000000ff rd_oe
P 00000000 00003c00 00000000 pins_in
R 00820008 00000000 00003c00 rd_in
W 0082000c 00000001 00000000 wr_ien
P 00000000 00003c01 00000000 pin0_rise
C 00000003 00000000 00000001 wake_gpio
R 00860000 00000000 00000001 raw_gpio
W 00820010 00000001 00000000 clr_stat
E 00000000 00000006 00000000 ext_on
R 00860000 00000000 0000000c raw_ext
C 00000002 00000000 00000000 irq_no_mask
W 00860004 00000008 00000000 wr_mask
C 00000002 00000000 00000001 irq_masked
W 00860008 00000001 00000000 hib_on
C 00000003 00000000 00000000 wake_hib_ext
P 00000000 00003c00 00000000 pin0_low
P 00000000 00003c01 00000000 pin0_rise2
C 00000003 00000000 00000001 wake_hib_gpio
W 00820010 00000001 00000000 clr_stat2
W 00860008 00000000 00000000 hib_off
C 00000003 00000000 00000001 wake_ext
R 00900000 00000001 00000000 rd_unmapped

/* sim.f */
design/soc_bus_pkg.sv
design/periph_regs_pkg.sv
design/apb_if.sv
design/ahb_apb_bridge.sv
design/gpio_apb.sv
design/irq_ctrl.sv
design/apb_subsystem.sv
verification/apb_subsystem_checker.sv
verification/tb_apb_subsystem.sv

/* Makefile */
# Verilator flow for the APB subsystem testbench
VERILATOR ?= verilator
TOP       ?= tb_apb_subsystem
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
PASS_MSG  ?= sim passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
